// File: verilog.f
logic/icache_cfg_pkg.sv
logic/icache_msg_pkg.sv
logic/icache_arrays.sv
logic/icache_lookup.sv
logic/icache_lru.sv
logic/icache_miss_ctrl.sv
logic/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the icache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -f verilog.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tests/icache_tb.sv
//****************************************
// icache testbench with clock, reset, fill
// engine, reference model, tests, watchdog
//****************************************
`timescale 1ns/1ps

module icache_tb
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
();

  localparam logic [ptag_width-1:0] ptag_offset = 20'h1c3a5;
  localparam int seed_init = 11;
  localparam int n_fetches = 26;
  localparam int n_fills = 9;
  localparam int run_cycles = 2 * (3 + sets + n_fetches * 16 + n_fills * (words_per_block + 2) * 4);

  typedef struct packed {
    logic                    is_miss;
    logic [paddr_width-1:0]  value;
    logic [way_id_width-1:0] way;
  } expect_s;

  logic      clk_i;
  logic      reset_i;
  vaddr_s    fetch_vaddr_i;
  logic      fetch_v_i;
  logic      ready_o;
  logic [ptag_width-1:0] ptag_i;
  logic      ptag_v_i;
  instr_t    data_o;
  logic      data_v_o;
  miss_req_s miss_req_o;
  logic      miss_req_v_o;
  logic      miss_req_ready_i;
  logic      miss_done_i;
  fill_pkt_s fill_pkt_i;
  logic      fill_v_i;
  logic      fill_yumi_o;

  // cache model of valid bits, tags and tree bits per set
  logic [ways-1:0]      m_valid [sets];
  logic [tag_width-1:0] m_tag [sets][ways];
  logic [2:0]           m_tree [sets];

  expect_s exp_q [$];
  int      errors;
  int      checks;
  int      test_err_start;
  string   test_name;

  icache_top u_dut (.*);

  bind icache_top icache_assert u_assert (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ready_o          (ready_o),
    .data_v_o         (data_v_o),
    .miss_req_v_o     (miss_req_v_o),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_done_i      (miss_done_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // memory contents as a hash of the word address
  function automatic instr_t mem_word(input logic [paddr_width-1:0] pa);
    logic [31:0] a;
    a = pa >> 2;
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [paddr_width-1:0] to_paddr(input vaddr_s va);
    logic [paddr_width-1:0] v;
    v = va;
    return {v[31:12] + ptag_offset, v[11:0]};
  endfunction

  // tree[0] picks the half, tree[1] the lower pair, tree[2] the upper pair
  function automatic logic [way_id_width-1:0] plru_victim(input logic [ways-1:0] valid,
                                                          input logic [2:0] tree);
    logic [way_id_width-1:0] way;
    logic                    found;
    way   = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    found = 1'b0;
    for (int w = 0; w < ways; w++) begin
      if (!found && !valid[w]) begin
        found = 1'b1;
        way   = way_id_width'(w);
      end
    end
    return way;
  endfunction

  function automatic logic [2:0] plru_touch(input logic [2:0] tree,
                                            input logic [way_id_width-1:0] way);
    logic [2:0] t;
    t    = tree;
    t[0] = ~way[1];
    if (way[1]) begin
      t[2] = ~way[0];
    end else begin
      t[1] = ~way[0];
    end
    return t;
  endfunction

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    $display("test %s done, %0d errors", test_name, errors - test_err_start);
  endtask

  // one fetch with tag_ok on ptag_v_i and stall cycles of miss_req_ready_i low
  task automatic fetch(input vaddr_s va, input logic tag_ok, input int stall);
    logic [paddr_width-1:0] pa;
    logic [index_width-1:0] idx;
    logic [tag_width-1:0]   tag;
    expect_s                e;
    int                     hit_way;
    pa  = to_paddr(va);
    idx = pa[9:4];
    tag = pa[31:10];
    fetch_vaddr_i = va;
    fetch_v_i     = 1'b1;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
    ptag_i    = pa[31:12];
    ptag_v_i  = tag_ok;
    if (stall > 0) begin
      miss_req_ready_i = 1'b0;
    end
    if (tag_ok) begin
      hit_way = -1;
      for (int w = ways - 1; w >= 0; w--) begin
        if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
          hit_way = w;
        end
      end
      e = '0;
      if (hit_way >= 0) begin
        e.value     = mem_word(pa);
        m_tree[idx] = plru_touch(m_tree[idx], way_id_width'(hit_way));
      end else begin
        e.is_miss = 1'b1;
        e.value   = {pa[31:4], 4'b0000};
        e.way     = plru_victim(m_valid[idx], m_tree[idx]);
      end
      exp_q.push_back(e);
    end
    @(posedge clk_i);
    #1;
    ptag_v_i = 1'b0;
    if (stall > 0) begin
      repeat (stall) begin
        @(negedge clk_i);
        checks++;
        if (ready_o || miss_req_v_o) begin
          errors++;
          $display("%s: ready or request seen while miss_req_ready_i is low", test_name);
        end
      end
      @(posedge clk_i);
      #1;
      miss_req_ready_i = 1'b1;
    end
  endtask

  task automatic send_fill(input fill_pkt_s pkt);
    logic yumi_exp;
    fill_pkt_i = pkt;
    fill_v_i   = 1'b1;
    @(negedge clk_i);
    // only a fetch accepted in this cycle may hold the packet back
    yumi_exp = !(fetch_v_i && ready_o);
    checks++;
    if (fill_yumi_o !== yumi_exp) begin
      errors++;
      $display("ERR %s yumi expected %b actual %b", test_name, yumi_exp, fill_yumi_o);
    end
    while (!fill_yumi_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    fill_v_i = 1'b0;
  endtask

  // no expectation left and the tracker back to idle
  task automatic wait_idle();
    @(negedge clk_i);
    while (exp_q.size() != 0 || !ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  // fill engine sends the tag first, then the four words, then done
  initial begin : fill_engine
    miss_req_s req;
    fill_pkt_s pkt;
    forever begin
      @(negedge clk_i);
      if (!reset_i && miss_req_v_o) begin
        req = miss_req_o;
        @(posedge clk_i);
        #1;
        pkt        = '0;
        pkt.opcode = tag_write;
        pkt.way_id = req.repl_way;
        pkt.index  = req.paddr.index;
        pkt.payload.tag_wr.valid = 1'b1;
        pkt.payload.tag_wr.ptag  = req.paddr.ptag;
        send_fill(pkt);
        m_valid[req.paddr.index][req.repl_way] = 1'b1;
        m_tag[req.paddr.index][req.repl_way]   = req.paddr.ptag;
        for (int ws = 0; ws < words_per_block; ws++) begin
          pkt        = '0;
          pkt.opcode = data_write;
          pkt.way_id = req.repl_way;
          pkt.index  = req.paddr.index;
          pkt.payload.data_wr.word_sel = word_sel_width'(ws);
          pkt.payload.data_wr.data =
            mem_word({req.paddr.ptag, req.paddr.index, word_sel_width'(ws), 2'b00});
          send_fill(pkt);
        end
        miss_done_i = 1'b1;
        @(posedge clk_i);
        #1;
        miss_done_i = 1'b0;
      end
    end
  end

  // compare every hit and every request against the model
  initial begin : compare
    expect_s e;
    forever begin
      @(negedge clk_i);
      if (!reset_i && (data_v_o || miss_req_v_o)) begin
        checks++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: DUT output with no fetch waiting for one", test_name);
        end else begin
          e = exp_q.pop_front();
          if (data_v_o && e.is_miss) begin
            errors++;
            $display("%s: hit returned where a miss was expected", test_name);
          end else if (data_v_o && data_o !== e.value) begin
            errors++;
            $display("ERR %s data expected %h actual %h", test_name, e.value, data_o);
          end else if (miss_req_v_o && !e.is_miss) begin
            errors++;
            $display("%s: miss request where a hit was expected", test_name);
          end else if (miss_req_v_o) begin
            if (miss_req_o.paddr !== e.value) begin
              errors++;
              $display("ERR %s addr expected %h actual %h", test_name, e.value,
                       miss_req_o.paddr);
            end
            if (miss_req_o.repl_way !== e.way) begin
              errors++;
              $display("ERR %s way expected %h actual %h", test_name, e.way,
                       miss_req_o.repl_way);
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (run_cycles) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", run_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    integer    seed;
    vaddr_s    va;
    vaddr_s    va2;
    vaddr_s    blk [5];
    logic [19:0] vpn;
    int        order [4];
    fill_pkt_s pkt;
    seed  = seed_init;
    order = '{2, 0, 3, 1};
    reset_i          = 1'b1;
    fetch_vaddr_i    = '0;
    fetch_v_i        = 1'b0;
    ptag_i           = '0;
    ptag_v_i         = 1'b0;
    miss_req_ready_i = 1'b1;
    miss_done_i      = 1'b0;
    fill_pkt_i       = '0;
    fill_v_i         = 1'b0;
    errors           = 0;
    checks           = 0;
    test_name        = "reset";
    for (int s = 0; s < sets; s++) begin
      m_valid[s] = '0;
      m_tree[s]  = '0;
      for (int w = 0; w < ways; w++) begin
        m_tag[s][w] = '0;
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // ready_o rises once the valid sweep is over
    wait_idle();

    start_test("cold_miss");
    va          = vaddr_s'($random(seed));
    va.byte_off = '0;
    fetch(va, 1'b1, 0);
    wait_idle();
    finish_test();

    start_test("block_hits");
    for (int ws = 0; ws < words_per_block; ws++) begin
      va2          = va;
      va2.word_sel = word_sel_width'(ws);
      fetch(va2, 1'b1, 0);
    end
    wait_idle();
    finish_test();

    start_test("lru_replace");
    vpn = 20'($random(seed));
    for (int i = 0; i < 5; i++) begin
      blk[i]             = vaddr_s'($random(seed));
      blk[i].byte_off    = '0;
      blk[i].index       = va.index + 6'd1;
      blk[i].vtag[21:2]  = vpn + 20'(i);
    end
    for (int i = 0; i < 4; i++) begin
      fetch(blk[i], 1'b1, 0);
      fetch(blk[i], 1'b1, 0);
    end
    foreach (order[k]) begin
      fetch(blk[order[k]], 1'b1, 0);
    end
    fetch(blk[4], 1'b1, 0);
    fetch(blk[4], 1'b1, 0);
    wait_idle();
    finish_test();

    start_test("req_stall");
    va2          = vaddr_s'($random(seed));
    va2.byte_off = '0;
    va2.index    = va.index + 6'd2;
    fetch(va2, 1'b1, 6);
    fetch(va2, 1'b1, 0);
    wait_idle();
    finish_test();

    start_test("ptag_drop");
    fetch(va, 1'b0, 0);
    va2.index = va.index + 6'd3;
    fetch(va2, 1'b0, 0);
    repeat (4) @(posedge clk_i);
    #1;
    fetch(va, 1'b1, 0);
    wait_idle();
    finish_test();

    start_test("set_inval");
    pkt        = '0;
    pkt.opcode = set_invalidate;
    pkt.index  = va.index;
    send_fill(pkt);
    m_valid[va.index] = '0;
    fetch(va, 1'b1, 0);
    fetch(va, 1'b1, 0);
    wait_idle();
    finish_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tests/icache_assert.sv
//****************************************
// handshake and pipeline assertions
// bound into the icache top level
//****************************************
`timescale 1ns/1ps

module icache_assert (
  input logic clk_i,
  input logic reset_i,
  input logic ready_o,
  input logic data_v_o,
  input logic miss_req_v_o,
  input logic miss_req_ready_i,
  input logic miss_done_i
);

  // set by a request, cleared by the fill engine's done
  logic in_flight_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight_r <= 1'b0;
    end else if (miss_req_v_o) begin
      in_flight_r <= 1'b1;
    end else if (miss_done_i) begin
      in_flight_r <= 1'b0;
    end
  end

  req_needs_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) miss_req_v_o |-> miss_req_ready_i
  ) else $error("miss request raised while miss_req_ready_i is low");

  hit_or_miss: assert property (
    @(posedge clk_i) disable iff (reset_i) !(data_v_o && miss_req_v_o)
  ) else $error("data_v_o and miss_req_v_o high in the same cycle");

  no_ready_in_flight: assert property (
    @(posedge clk_i) disable iff (reset_i) in_flight_r |-> !ready_o
  ) else $error("ready_o high while a miss is in flight");

endmodule

// File: logic/icache_top.sv
//****************************************
// icache top level, connects arrays,
// lookup pipeline, lru and miss tracker
//****************************************
`timescale 1ns/1ps

module icache_top
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vaddr_s                  fetch_vaddr_i,
  input  logic                    fetch_v_i,
  output logic                    ready_o,
  input  logic [ptag_width-1:0]   ptag_i,
  input  logic                    ptag_v_i,
  output instr_t                  data_o,
  output logic                    data_v_o,
  output miss_req_s               miss_req_o,
  output logic                    miss_req_v_o,
  input  logic                    miss_req_ready_i,
  input  logic                    miss_done_i,
  input  fill_pkt_s               fill_pkt_i,
  input  logic                    fill_v_i,
  output logic                    fill_yumi_o
);

  logic                                                 rd_en;
  logic [index_width-1:0]                               rd_index;
  logic [ways-1:0][tag_width-1:0]                       way_tag;
  logic [ways-1:0]                                      way_valid;
  logic [ways-1:0][words_per_block-1:0][word_width-1:0] way_word;
  logic                                                 init_done;
  logic                                                 hold;
  logic [way_id_width-1:0]                              tv_hit_way;
  logic                                                 tv_hit;
  logic                                                 tv_miss;
  paddr_s                                               tv_paddr;
  logic [index_width-1:0]                               tv_index;
  logic [ways-1:0]                                      tv_way_valid;
  logic [way_id_width-1:0]                              repl_way;

  icache_arrays u_arrays (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .fill_pkt_i  (fill_pkt_i),
    .fill_v_i    (fill_v_i),
    .fill_yumi_o (fill_yumi_o),
    .way_tag_o   (way_tag),
    .way_valid_o (way_valid),
    .way_word_o  (way_word),
    .init_done_o (init_done)
  );

  icache_lookup u_lookup (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_vaddr_i  (fetch_vaddr_i),
    .fetch_v_i      (fetch_v_i),
    .ready_i        (ready_o),
    .rd_en_o        (rd_en),
    .rd_index_o     (rd_index),
    .ptag_i         (ptag_i),
    .ptag_v_i       (ptag_v_i),
    .way_tag_i      (way_tag),
    .way_valid_i    (way_valid),
    .way_word_i     (way_word),
    .hold_i         (hold),
    .tv_hit_way_o   (tv_hit_way),
    .tv_hit_o       (tv_hit),
    .tv_miss_o      (tv_miss),
    .tv_paddr_o     (tv_paddr),
    .tv_index_o     (tv_index),
    .tv_way_valid_o (tv_way_valid),
    .data_o         (data_o),
    .data_v_o       (data_v_o)
  );

  icache_lru u_lru (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .tv_index_i   (tv_index),
    .way_valid_i  (tv_way_valid),
    .tv_hit_i     (tv_hit),
    .tv_hit_way_i (tv_hit_way),
    .repl_way_o   (repl_way)
  );

  icache_miss_ctrl u_miss_ctrl (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .init_done_i      (init_done),
    .tv_miss_i        (tv_miss),
    .tv_paddr_i       (tv_paddr),
    .repl_way_i       (repl_way),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_done_i      (miss_done_i),
    .miss_req_o       (miss_req_o),
    .miss_req_v_o     (miss_req_v_o),
    .ready_o          (ready_o),
    .hold_o           (hold)
  );

endmodule

// File: logic/icache_miss_ctrl.sv
//****************************************
// miss request build and ready tracker
//****************************************
`timescale 1ns/1ps

module icache_miss_ctrl
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    init_done_i,
  input  logic                    tv_miss_i,
  input  paddr_s                  tv_paddr_i,
  input  logic [way_id_width-1:0] repl_way_i,
  input  logic                    miss_req_ready_i,
  input  logic                    miss_done_i,
  output miss_req_s               miss_req_o,
  output logic                    miss_req_v_o,
  output logic                    ready_o,
  output logic                    hold_o
);

  typedef enum logic [1:0] {
    st_init,
    st_ready,
    st_wait_fill
  } state_e;

  state_e state_r;
  state_e state_n;

  // request only goes out in a cycle the engine can take it
  assign miss_req_v_o = (state_r == st_ready) & tv_miss_i & miss_req_ready_i;

  always_comb begin
    miss_req_o                = '0;
    miss_req_o.paddr          = tv_paddr_i;
    miss_req_o.paddr.word_sel = '0;
    miss_req_o.paddr.byte_off = '0;
    miss_req_o.repl_way       = repl_way_i;
  end

  assign ready_o = (state_r == st_ready) & ~tv_miss_i & miss_req_ready_i;
  assign hold_o  = (tv_miss_i & ~miss_req_v_o) | (state_r == st_wait_fill);

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_init:      state_n = init_done_i ? st_ready : st_init;
      st_ready:     state_n = miss_req_v_o ? st_wait_fill : st_ready;
      st_wait_fill: state_n = miss_done_i ? st_ready : st_wait_fill;
      default:      state_n = st_init;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_init;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// File: logic/icache_lru.sv
//****************************************
// pseudo-LRU tree bits per set, hit update
// and replacement way choice
//****************************************
`timescale 1ns/1ps

module icache_lru
  import icache_cfg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [index_width-1:0]  tv_index_i,
  input  logic [ways-1:0]         way_valid_i,
  input  logic                    tv_hit_i,
  input  logic [way_id_width-1:0] tv_hit_way_i,
  output logic [way_id_width-1:0] repl_way_o
);

  logic [sets-1:0][ways-2:0] lru_r;
  logic [ways-2:0]           lru_tv;
  logic [ways-2:0]           lru_upd;
  logic [way_id_width-1:0]   lru_way;
  logic [way_id_width-1:0]   inv_way;
  logic                      inv_found;

  assign lru_tv = lru_r[tv_index_i];

  // bit 0 picks the half, bit 1 the lower pair, bit 2 the upper pair
  assign lru_way[1] = lru_tv[0];
  assign lru_way[0] = lru_tv[0] ? lru_tv[2] : lru_tv[1];

  // point away from the hit way, other pair untouched
  always_comb begin
    lru_upd    = lru_tv;
    lru_upd[0] = ~tv_hit_way_i[1];
    if (tv_hit_way_i[1]) begin
      lru_upd[2] = ~tv_hit_way_i[0];
    end else begin
      lru_upd[1] = ~tv_hit_way_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
    end else if (tv_hit_i) begin
      lru_r[tv_index_i] <= lru_upd;
    end
  end

  // an empty way wins over the tree
  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        inv_found = 1'b1;
        inv_way   = way_id_width'(w);
      end
    end
  end

  assign repl_way_o = inv_found ? inv_way : lru_way;

endmodule

// File: logic/icache_lookup.sv
//****************************************
// TL and TV pipeline stages, tag compare
// and hit word select
//****************************************
`timescale 1ns/1ps

module icache_lookup
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  vaddr_s                                               fetch_vaddr_i,
  input  logic                                                 fetch_v_i,
  input  logic                                                 ready_i,
  output logic                                                 rd_en_o,
  output logic [index_width-1:0]                               rd_index_o,
  input  logic [ptag_width-1:0]                                ptag_i,
  input  logic                                                 ptag_v_i,
  input  logic [ways-1:0][tag_width-1:0]                       way_tag_i,
  input  logic [ways-1:0]                                      way_valid_i,
  input  logic [ways-1:0][words_per_block-1:0][word_width-1:0] way_word_i,
  input  logic                                                 hold_i,
  output logic [way_id_width-1:0]                              tv_hit_way_o,
  output logic                                                 tv_hit_o,
  output logic                                                 tv_miss_o,
  output paddr_s                                               tv_paddr_o,
  output logic [index_width-1:0]                               tv_index_o,
  output logic [ways-1:0]                                      tv_way_valid_o,
  output instr_t                                               data_o,
  output logic                                                 data_v_o
);

  logic                                                 tl_v_r;
  vaddr_s                                               vaddr_tl_r;
  paddr_s                                               paddr_tl;
  logic [ways-1:0]                                      hit_tl;
  logic                                                 tv_v_r;
  paddr_s                                               paddr_tv_r;
  logic [ways-1:0]                                      hit_tv_r;
  logic [ways-1:0]                                      valid_tv_r;
  logic [ways-1:0][words_per_block-1:0][word_width-1:0] block_tv_r;

  // acceptance starts the array read
  assign rd_en_o    = fetch_v_i & ready_i;
  assign rd_index_o = fetch_vaddr_i.index;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= rd_en_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      vaddr_tl_r <= fetch_vaddr_i;
    end
  end

  // late ptag plus the untranslated page offset
  assign paddr_tl = paddr_s'({ptag_i, vaddr_tl_r[page_offset_width-1:0]});

  for (genvar w = 0; w < ways; w++) begin : g_cmp
    assign hit_tl[w] = way_valid_i[w] & (way_tag_i[w] == paddr_tl.ptag);
  end

  // no ptag means drop, and a pending miss discards the TL item
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else if (!hold_i) begin
      tv_v_r <= tl_v_r & ptag_v_i & ~tv_miss_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_i && tl_v_r && ptag_v_i) begin
      paddr_tv_r <= paddr_tl;
      hit_tv_r   <= hit_tl;
      valid_tv_r <= way_valid_i;
      block_tv_r <= way_word_i;
    end
  end

  assign tv_hit_o  = tv_v_r & (|hit_tv_r);
  assign tv_miss_o = tv_v_r & ~(|hit_tv_r);
  assign data_v_o  = tv_hit_o;

  // lowest hitting way
  always_comb begin
    tv_hit_way_o = '0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (hit_tv_r[w]) begin
        tv_hit_way_o = way_id_width'(w);
      end
    end
  end

  assign data_o         = block_tv_r[tv_hit_way_o][paddr_tv_r.word_sel];
  assign tv_paddr_o     = paddr_tv_r;
  assign tv_index_o     = paddr_tv_r.index;
  assign tv_way_valid_o = valid_tv_r;

endmodule

// File: logic/icache_arrays.sv
//****************************************
// tag and data arrays, fill packet writes
// and the valid bit sweep after reset
//****************************************
`timescale 1ns/1ps

module icache_arrays
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic                                                 rd_en_i,
  input  logic [index_width-1:0]                               rd_index_i,
  input  fill_pkt_s                                            fill_pkt_i,
  input  logic                                                 fill_v_i,
  output logic                                                 fill_yumi_o,
  output logic [ways-1:0][tag_width-1:0]                       way_tag_o,
  output logic [ways-1:0]                                      way_valid_o,
  output logic [ways-1:0][words_per_block-1:0][word_width-1:0] way_word_o,
  output logic                                                 init_done_o
);

  tag_entry_s [ways-1:0]                      tag_mem [sets];
  logic [words_per_block-1:0][word_width-1:0] data_mem [ways][sets];

  tag_entry_s [ways-1:0]       tag_rd_r;
  logic                        sweep_v_r;
  logic [index_width-1:0]      sweep_idx_r;
  logic                        fill_tag_we;
  logic                        fill_inval_we;
  logic                        fill_data_we;
  tag_entry_s                  fill_entry;
  logic [word_sel_width-1:0]   fill_word_sel;
  instr_t                      fill_word;

  // a read on fetch acceptance owns the single port
  assign fill_yumi_o   = fill_v_i & ~rd_en_i & ~sweep_v_r;
  assign fill_tag_we   = fill_yumi_o & (fill_pkt_i.opcode == tag_write);
  assign fill_inval_we = fill_yumi_o & (fill_pkt_i.opcode == set_invalidate);
  assign fill_data_we  = fill_yumi_o & (fill_pkt_i.opcode == data_write);

  assign fill_entry.valid = fill_pkt_i.payload.tag_wr.valid;
  assign fill_entry.tag   = fill_pkt_i.payload.tag_wr.ptag;
  assign fill_word_sel    = fill_pkt_i.payload.data_wr.word_sel;
  assign fill_word        = fill_pkt_i.payload.data_wr.data;

  // one set per cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sweep_v_r   <= 1'b1;
      sweep_idx_r <= '0;
    end else if (sweep_v_r) begin
      sweep_idx_r <= sweep_idx_r + 1'b1;
      if (sweep_idx_r == index_width'(sets - 1)) begin
        sweep_v_r <= 1'b0;
      end
    end
  end

  assign init_done_o = ~sweep_v_r;

  always_ff @(posedge clk_i) begin
    if (sweep_v_r) begin
      tag_mem[sweep_idx_r] <= '0;
    end else if (fill_inval_we) begin
      tag_mem[fill_pkt_i.index] <= '0;
    end else if (fill_tag_we) begin
      tag_mem[fill_pkt_i.index][fill_pkt_i.way_id] <= fill_entry;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_data_we) begin
      data_mem[fill_pkt_i.way_id][fill_pkt_i.index][fill_word_sel] <= fill_word;
    end
  end

  // read data stays put until the next fetch
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      tag_rd_r <= tag_mem[rd_index_i];
      for (int w = 0; w < ways; w++) begin
        way_word_o[w] <= data_mem[w][rd_index_i];
      end
    end
  end

  for (genvar w = 0; w < ways; w++) begin : g_way_out
    assign way_tag_o[w]   = tag_rd_r[w].tag;
    assign way_valid_o[w] = tag_rd_r[w].valid;
  end

endmodule

// File: logic/icache_msg_pkg.sv
//****************************************
// fetch word, miss request and fill
// packet types with the payload union
//****************************************
package icache_msg_pkg;
  import icache_cfg_pkg::*;

  typedef logic [word_width-1:0] instr_t;

  // block-aligned miss with the way the fill should land in
  typedef struct packed {
    paddr_s                  paddr;
    logic [way_id_width-1:0] repl_way;
  } miss_req_s;

  typedef enum logic [1:0] {
    tag_write      = 2'd0,
    set_invalidate = 2'd1,
    data_write     = 2'd2
  } fill_op_e;

  localparam int fill_pad_width = word_sel_width + word_width - 1 - tag_width;

  typedef struct packed {
    logic [fill_pad_width-1:0] pad;
    logic                      valid;
    logic [tag_width-1:0]      ptag;
  } tag_fill_s;

  typedef struct packed {
    logic [word_sel_width-1:0] word_sel;
    instr_t                    data;
  } data_fill_s;

  // opcode decides which view applies
  typedef union packed {
    tag_fill_s  tag_wr;
    data_fill_s data_wr;
  } fill_payload_u;

  typedef struct packed {
    fill_op_e                opcode;
    logic [way_id_width-1:0] way_id;
    logic [index_width-1:0]  index;
    fill_payload_u           payload;
  } fill_pkt_s;

endpackage

// File: logic/icache_cfg_pkg.sv
//****************************************
// icache geometry constants, fetch and
// physical address layouts, tag entry
//****************************************
package icache_cfg_pkg;

  localparam int ways = 4;
  localparam int sets = 64;
  localparam int words_per_block = 4;
  localparam int word_width = 32;
  localparam int paddr_width = 32;
  localparam int page_offset_width = 12;
  localparam int ptag_width = 20;
  localparam int index_width = 6;
  localparam int word_sel_width = 2;
  localparam int byte_off_width = 2;
  localparam int way_id_width = 2;
  // stored tag also covers the page offset bits above the index
  localparam int tag_width = paddr_width - index_width - word_sel_width - byte_off_width;

  typedef struct packed {
    logic [tag_width-1:0]      vtag;
    logic [index_width-1:0]    index;
    logic [word_sel_width-1:0] word_sel;
    logic [byte_off_width-1:0] byte_off;
  } vaddr_s;

  typedef struct packed {
    logic [tag_width-1:0]      ptag;
    logic [index_width-1:0]    index;
    logic [word_sel_width-1:0] word_sel;
    logic [byte_off_width-1:0] byte_off;
  } paddr_s;

  typedef struct packed {
    logic                 valid;
    logic [tag_width-1:0] tag;
  } tag_entry_s;

endpackage
